// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// widths with a meaning
	localparam int unsigned WORD_WIDTH = 32;
	localparam int unsigned HALF_WIDTH = 16;
	localparam int unsigned REG_ADDR_WIDTH = 5;
	localparam int unsigned NUM_REGS = 32;
	localparam int unsigned INST_ADDR_WIDTH = 11;
	localparam int unsigned OPCODE_WIDTH = 5;
	localparam int unsigned SHAMT_WIDTH = 5;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [HALF_WIDTH-1:0] half_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [2:0] branch_cond_t;

	// instruction layout, lsb of each field
	localparam int unsigned OPCODE_LSB = 27;
	localparam int unsigned DEST_LSB = 22;
	localparam int unsigned COND_LSB = 24;
	localparam int unsigned SOURCE1_LSB = 17;
	localparam int unsigned SOURCE2_LSB = 12;
	localparam int unsigned IMM_LSB = 0;

	// opcodes, everything else is a no-op
	localparam opcode_t OP_ADD = 5'd0;
	localparam opcode_t OP_ADDI = 5'd1;
	localparam opcode_t OP_SUB = 5'd2;
	localparam opcode_t OP_AND = 5'd3;
	localparam opcode_t OP_ANDI = 5'd4;
	localparam opcode_t OP_OR = 5'd5;
	localparam opcode_t OP_ORI = 5'd6;
	localparam opcode_t OP_XOR = 5'd7;
	localparam opcode_t OP_SLL = 5'd8;
	localparam opcode_t OP_SRL = 5'd9;
	localparam opcode_t OP_SRA = 5'd10;
	localparam opcode_t OP_LLI = 5'd11;
	localparam opcode_t OP_LUI = 5'd12;
	localparam opcode_t OP_B = 5'd17;
	localparam opcode_t OP_BL = 5'd18;
	localparam opcode_t OP_RET = 5'd19;
	localparam opcode_t OP_TIM = 5'd29;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLL = 3'd5;
	localparam alu_op_t ALU_SRL = 3'd6;
	localparam alu_op_t ALU_SRA = 3'd7;

	localparam branch_cond_t COND_NE = 3'd0;
	localparam branch_cond_t COND_EQ = 3'd1;
	localparam branch_cond_t COND_GT = 3'd2;
	localparam branch_cond_t COND_LT = 3'd3;
	localparam branch_cond_t COND_GE = 3'd4;
	localparam branch_cond_t COND_LE = 3'd5;
	localparam branch_cond_t COND_OVERFLOW = 3'd6;
	localparam branch_cond_t COND_ALWAYS = 3'd7;

	// timer prescale, kept tiny so time moves in simulation
	localparam int unsigned CYCLES_PER_MS = 4;
	localparam int unsigned PRESCALE_WIDTH = $clog2(CYCLES_PER_MS);

	typedef struct packed {
		alu_op_t alu_op;
		logic use_immediate;
		logic select_immediate;
		logic select_time;
		logic update_cc;
		reg_addr_t source1;
		reg_addr_t source2;
	} ex_ctrl_t;

	typedef struct packed {
		reg_addr_t dest;
		logic write_full;
		logic write_lower;
		logic write_upper;
	} wb_ctrl_t;

endpackage

// ==== logic/wb_bus_if.sv ====
`timescale 1ns/10ps

interface wb_bus_if;
	import cpu_pkg::*;

	// at most one strobe high, all low for a bubble
	logic write_full;
	logic write_lower;
	logic write_upper;
	reg_addr_t dest;
	word_t data;

	modport producer (
		output write_full, write_lower, write_upper, dest, data
	);

	modport sink (
		input write_full, write_lower, write_upper, dest, data
	);

	modport observer (
		input write_full, write_lower, write_upper, dest, data
	);

endinterface

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic load_write,
	input cpu_pkg::inst_addr_t load_address,
	input cpu_pkg::word_t load_instruction,
	input logic stall,
	input logic redirect,
	input cpu_pkg::inst_addr_t target,
	input logic link,
	input cpu_pkg::inst_addr_t link_address,
	input logic ret,
	output cpu_pkg::word_t instruction,
	output cpu_pkg::inst_addr_t instruction_pc,
	output logic bubble
);
	import cpu_pkg::*;

	word_t imem [0:(2**INST_ADDR_WIDTH)-1];
	word_t mem_data;
	inst_addr_t pc_q;
	inst_addr_t pc_next;
	inst_addr_t link_q;
	logic load_q;
	logic hold;

	// one extra cycle of hold so the first read follows the last write
	assign hold = load || load_q;

	always_comb begin
		if (hold) begin
			pc_next = '0;
		end else if (redirect) begin
			pc_next = target;
		end else if (ret) begin
			pc_next = link_q;
		end else if (stall) begin
			pc_next = pc_q;
		end else begin
			pc_next = pc_q + inst_addr_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_q <= 1'b1;
			pc_q <= '0;
			link_q <= '0;
			bubble <= 1'b1;
		end else begin
			load_q <= load;
			pc_q <= pc_next;
			if (link) begin
				link_q <= link_address;
			end
			// wrong-path word is dropped on a redirect
			if (hold || redirect || ret) begin
				bubble <= 1'b1;
			end else if (!stall) begin
				bubble <= 1'b0;
			end
		end
	end

	// program port and synchronous read, mem_data belongs to pc_q
	always_ff @(posedge clk) begin
		if (load && load_write) begin
			imem[load_address] <= load_instruction;
		end
		mem_data <= imem[pc_next];
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instruction <= mem_data;
			instruction_pc <= pc_q;
		end
	end

	redirect_ret_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n) !(redirect && ret)
	);

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::word_t instruction,
	input cpu_pkg::inst_addr_t instruction_pc,
	input logic bubble,
	input cpu_pkg::word_t read1_data,
	input cpu_pkg::word_t read2_data,
	input logic cc_update,
	input logic cc_next_zero,
	input logic cc_next_sign,
	input logic cc_next_overflow,
	output cpu_pkg::reg_addr_t read1_address,
	output cpu_pkg::reg_addr_t read2_address,
	output logic redirect,
	output cpu_pkg::inst_addr_t target,
	output logic link,
	output cpu_pkg::inst_addr_t link_address,
	output logic ret,
	output logic stall,
	output cpu_pkg::word_t op1,
	output cpu_pkg::word_t op2,
	output cpu_pkg::word_t immediate,
	output cpu_pkg::ex_ctrl_t ex_ctrl,
	output cpu_pkg::wb_ctrl_t wb_ctrl,
	output logic ex_bubble,
	wb_bus_if.observer wb
);
	import cpu_pkg::*;

	opcode_t opcode;
	branch_cond_t cond;
	half_t imm_half;
	word_t imm_ext;
	ex_ctrl_t ex_next;
	wb_ctrl_t wb_next;
	logic is_branch;
	logic is_link;
	logic is_ret;
	logic taken;
	logic hz_cc;
	logic hz_half;
	logic cc_zero;
	logic cc_sign;
	logic cc_overflow;

	assign opcode = instruction[OPCODE_LSB +: OPCODE_WIDTH];
	assign cond = instruction[COND_LSB +: $bits(branch_cond_t)];
	assign imm_half = instruction[IMM_LSB +: HALF_WIDTH];
	assign imm_ext = {{(WORD_WIDTH-HALF_WIDTH){imm_half[HALF_WIDTH-1]}}, imm_half};
	assign read1_address = instruction[SOURCE1_LSB +: REG_ADDR_WIDTH];
	assign read2_address = instruction[SOURCE2_LSB +: REG_ADDR_WIDTH];

	//////////////////////////////////////////////////////////////////////
	// opcode decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ex_next = '0;
		wb_next = '0;
		is_branch = 1'b0;
		is_link = 1'b0;
		is_ret = 1'b0;
		ex_next.source1 = read1_address;
		ex_next.source2 = read2_address;
		wb_next.dest = instruction[DEST_LSB +: REG_ADDR_WIDTH];
		case (opcode)
			OP_ADD, OP_ADDI: ex_next.alu_op = ALU_ADD;
			OP_SUB: ex_next.alu_op = ALU_SUB;
			OP_AND, OP_ANDI: ex_next.alu_op = ALU_AND;
			OP_OR, OP_ORI: ex_next.alu_op = ALU_OR;
			OP_XOR: ex_next.alu_op = ALU_XOR;
			OP_SLL: ex_next.alu_op = ALU_SLL;
			OP_SRL: ex_next.alu_op = ALU_SRL;
			OP_SRA: ex_next.alu_op = ALU_SRA;
			OP_LLI: begin
				ex_next.select_immediate = 1'b1;
				wb_next.write_lower = 1'b1;
			end
			OP_LUI: begin
				ex_next.select_immediate = 1'b1;
				wb_next.write_upper = 1'b1;
			end
			OP_B: is_branch = 1'b1;
			OP_BL: begin
				is_branch = 1'b1;
				is_link = 1'b1;
			end
			OP_RET: is_ret = 1'b1;
			OP_TIM: begin
				ex_next.select_time = 1'b1;
				wb_next.write_full = 1'b1;
			end
			default: ;
		endcase
		// every alu opcode sits below lli
		if (opcode <= OP_SRA) begin
			ex_next.update_cc = 1'b1;
			wb_next.write_full = 1'b1;
		end
		ex_next.use_immediate = (opcode == OP_ADDI) || (opcode == OP_ANDI) ||
			(opcode == OP_ORI);
	end

	// condition codes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cc_zero <= 1'b0;
			cc_sign <= 1'b0;
			cc_overflow <= 1'b0;
		end else if (cc_update) begin
			cc_zero <= cc_next_zero;
			cc_sign <= cc_next_sign;
			cc_overflow <= cc_next_overflow;
		end
	end

	always_comb begin
		case (cond)
			COND_NE: taken = !cc_zero;
			COND_EQ: taken = cc_zero;
			COND_GT: taken = !cc_zero && !cc_sign;
			COND_LT: taken = !cc_zero && cc_sign;
			COND_GE: taken = cc_zero || !cc_sign;
			COND_LE: taken = cc_zero || cc_sign;
			COND_OVERFLOW: taken = cc_overflow;
			COND_ALWAYS: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// hazards and control flow
	//////////////////////////////////////////////////////////////////////

	// flags from the op in execute are not written yet
	assign hz_cc = is_branch && ex_ctrl.update_cc;
	// half writes are never forwarded, wait for write-through
	assign hz_half = (wb_ctrl.write_lower || wb_ctrl.write_upper) &&
		((wb_ctrl.dest == read1_address) || (wb_ctrl.dest == read2_address));
	assign stall = (hz_cc || hz_half) && !bubble;

	assign link_address = instruction_pc + inst_addr_t'(1);
	assign target = link_address + imm_ext[INST_ADDR_WIDTH-1:0];
	assign redirect = is_branch && taken && !stall && !bubble;
	assign link = is_link && taken && !stall && !bubble;
	assign ret = is_ret && !stall && !bubble;

	// ID/EX register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
			wb_ctrl <= '0;
			ex_bubble <= 1'b1;
		end else if (bubble || stall) begin
			ex_ctrl <= '0;
			wb_ctrl <= '0;
			ex_bubble <= 1'b1;
		end else begin
			ex_ctrl <= ex_next;
			wb_ctrl <= wb_next;
			ex_bubble <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		op1 <= read1_data;
		op2 <= read2_data;
		immediate <= imm_ext;
	end

	no_stall_on_redirect: assert property (
		@(posedge clk) disable iff (!rst_n) !(stall && redirect)
	);

	// a one-cycle half-write stall only works if the write lands next cycle
	half_write_reaches_wb: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wb_ctrl.write_lower || wb_ctrl.write_upper) |=>
		((wb.write_lower || wb.write_upper) && (wb.dest == $past(wb_ctrl.dest)))
	);

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/10ps

module register_file (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::reg_addr_t read1_address,
	input cpu_pkg::reg_addr_t read2_address,
	output cpu_pkg::word_t read1_data,
	output cpu_pkg::word_t read2_data,
	wb_bus_if.sink wb
);
	import cpu_pkg::*;

	word_t regs [0:NUM_REGS-1];
	word_t merged;
	half_t write_half;
	logic any_write;

	assign any_write = wb.write_full || wb.write_lower || wb.write_upper;
	assign write_half = wb.data[HALF_WIDTH-1:0];

	// new value of the written register, half writes keep the other half
	always_comb begin
		if (wb.write_full) begin
			merged = wb.data;
		end else if (wb.write_lower) begin
			merged = {regs[wb.dest][WORD_WIDTH-1:HALF_WIDTH], write_half};
		end else begin
			merged = {write_half, regs[wb.dest][HALF_WIDTH-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (any_write && (wb.dest != '0)) begin
			regs[wb.dest] <= merged;
		end
	end

	// r0 reads as zero, otherwise write-through
	always_comb begin
		if (read1_address == '0) begin
			read1_data = '0;
		end else if (any_write && (wb.dest == read1_address)) begin
			read1_data = merged;
		end else begin
			read1_data = regs[read1_address];
		end
	end

	always_comb begin
		if (read2_address == '0) begin
			read2_data = '0;
		end else if (any_write && (wb.dest == read2_address)) begin
			read2_data = merged;
		end else begin
			read2_data = regs[read2_address];
		end
	end

	one_write_strobe: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({wb.write_full, wb.write_lower, wb.write_upper})
	);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::word_t op1,
	input cpu_pkg::word_t op2,
	input cpu_pkg::word_t immediate,
	input cpu_pkg::ex_ctrl_t ex_ctrl,
	input cpu_pkg::wb_ctrl_t wb_ctrl,
	input logic ex_bubble,
	input cpu_pkg::word_t time_ms,
	output logic cc_update,
	output logic cc_next_zero,
	output logic cc_next_sign,
	output logic cc_next_overflow,
	wb_bus_if.producer wb_out,
	wb_bus_if.observer wb_in
);
	import cpu_pkg::*;

	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t result;
	logic alu_overflow;
	logic fwd1;
	logic fwd2;
	wb_ctrl_t wb_q;
	word_t result_q;

	// writeback to execute forwarding, r0 never forwards
	assign fwd1 = wb_in.write_full && (wb_in.dest != '0) && (wb_in.dest == ex_ctrl.source1);
	assign fwd2 = wb_in.write_full && (wb_in.dest != '0) && (wb_in.dest == ex_ctrl.source2);

	assign alu_a = fwd1 ? wb_in.data : op1;
	assign alu_b = ex_ctrl.use_immediate ? immediate : fwd2 ? wb_in.data : op2;

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_result = alu_a + alu_b;
		alu_overflow = 1'b0;
		case (ex_ctrl.alu_op)
			ALU_ADD: begin
				alu_overflow = (alu_a[WORD_WIDTH-1] == alu_b[WORD_WIDTH-1]) &&
					(alu_result[WORD_WIDTH-1] != alu_a[WORD_WIDTH-1]);
			end
			ALU_SUB: begin
				alu_result = alu_a - alu_b;
				alu_overflow = (alu_a[WORD_WIDTH-1] != alu_b[WORD_WIDTH-1]) &&
					(alu_result[WORD_WIDTH-1] != alu_a[WORD_WIDTH-1]);
			end
			ALU_AND: alu_result = alu_a & alu_b;
			ALU_OR: alu_result = alu_a | alu_b;
			ALU_XOR: alu_result = alu_a ^ alu_b;
			ALU_SLL: alu_result = alu_a << alu_b[SHAMT_WIDTH-1:0];
			ALU_SRL: alu_result = alu_a >> alu_b[SHAMT_WIDTH-1:0];
			ALU_SRA: alu_result = word_t'($signed(alu_a) >>> alu_b[SHAMT_WIDTH-1:0]);
			default: alu_result = alu_a + alu_b;
		endcase
	end

	assign cc_update = ex_ctrl.update_cc && !ex_bubble;
	assign cc_next_zero = (alu_result == '0);
	assign cc_next_sign = alu_result[WORD_WIDTH-1];
	assign cc_next_overflow = alu_overflow;

	// lli and lui carry the immediate, only its low half is written
	assign result = ex_ctrl.select_time ? time_ms :
		ex_ctrl.select_immediate ? immediate :
		alu_result;

	// EX/WB register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q <= '0;
		end else if (ex_bubble) begin
			wb_q <= '0;
		end else begin
			wb_q <= wb_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		result_q <= result;
	end

	assign wb_out.write_full = wb_q.write_full;
	assign wb_out.write_lower = wb_q.write_lower;
	assign wb_out.write_upper = wb_q.write_upper;
	assign wb_out.dest = wb_q.dest;
	assign wb_out.data = result_q;

endmodule

// ==== logic/system_timer.sv ====
`timescale 1ns/10ps

module system_timer (
	input logic clk,
	input logic rst_n,
	output cpu_pkg::word_t time_ms
);
	import cpu_pkg::*;

	logic [PRESCALE_WIDTH-1:0] prescale;
	logic tick;

	assign tick = (prescale == PRESCALE_WIDTH'(CYCLES_PER_MS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescale <= '0;
			time_ms <= '0;
		end else if (tick) begin
			prescale <= '0;
			time_ms <= time_ms + word_t'(1);
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	prescale_in_range: assert property (
		@(posedge clk) disable iff (!rst_n) prescale < CYCLES_PER_MS
	);

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic load_write,
	input cpu_pkg::inst_addr_t load_address,
	input cpu_pkg::word_t load_instruction,
	output logic retire,
	output cpu_pkg::reg_addr_t retire_dest,
	output cpu_pkg::word_t retire_data
);
	import cpu_pkg::*;

	// fetch and decode
	word_t if_instruction;
	inst_addr_t if_pc;
	logic if_bubble;
	logic stall;
	logic redirect;
	inst_addr_t target;
	logic link;
	inst_addr_t link_address;
	logic ret;

	reg_addr_t read1_address;
	reg_addr_t read2_address;
	word_t read1_data;
	word_t read2_data;

	// decode to execute
	word_t op1;
	word_t op2;
	word_t immediate;
	ex_ctrl_t ex_ctrl;
	wb_ctrl_t wb_ctrl;
	logic ex_bubble;
	logic cc_update;
	logic cc_next_zero;
	logic cc_next_sign;
	logic cc_next_overflow;
	word_t time_ms;

	wb_bus_if wb_bus();

	fetch_stage i_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.load_write(load_write),
		.load_address(load_address),
		.load_instruction(load_instruction),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.link(link),
		.link_address(link_address),
		.ret(ret),
		.instruction(if_instruction),
		.instruction_pc(if_pc),
		.bubble(if_bubble)
	);

	decode_stage i_decode (
		.clk(clk),
		.rst_n(rst_n),
		.instruction(if_instruction),
		.instruction_pc(if_pc),
		.bubble(if_bubble),
		.read1_data(read1_data),
		.read2_data(read2_data),
		.cc_update(cc_update),
		.cc_next_zero(cc_next_zero),
		.cc_next_sign(cc_next_sign),
		.cc_next_overflow(cc_next_overflow),
		.read1_address(read1_address),
		.read2_address(read2_address),
		.redirect(redirect),
		.target(target),
		.link(link),
		.link_address(link_address),
		.ret(ret),
		.stall(stall),
		.op1(op1),
		.op2(op2),
		.immediate(immediate),
		.ex_ctrl(ex_ctrl),
		.wb_ctrl(wb_ctrl),
		.ex_bubble(ex_bubble),
		.wb(wb_bus.observer)
	);

	register_file i_register_file (
		.clk(clk),
		.rst_n(rst_n),
		.read1_address(read1_address),
		.read2_address(read2_address),
		.read1_data(read1_data),
		.read2_data(read2_data),
		.wb(wb_bus.sink)
	);

	execute_stage i_execute (
		.clk(clk),
		.rst_n(rst_n),
		.op1(op1),
		.op2(op2),
		.immediate(immediate),
		.ex_ctrl(ex_ctrl),
		.wb_ctrl(wb_ctrl),
		.ex_bubble(ex_bubble),
		.time_ms(time_ms),
		.cc_update(cc_update),
		.cc_next_zero(cc_next_zero),
		.cc_next_sign(cc_next_sign),
		.cc_next_overflow(cc_next_overflow),
		.wb_out(wb_bus.producer),
		.wb_in(wb_bus.observer)
	);

	system_timer i_timer (
		.clk(clk),
		.rst_n(rst_n),
		.time_ms(time_ms)
	);

	// trace of full writes only
	assign retire = wb_bus.write_full;
	assign retire_dest = wb_bus.dest;
	assign retire_data = wb_bus.data;

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;
	import cpu_pkg::*;

	logic clk;
	logic rst_n;
	logic load;
	logic load_write;
	inst_addr_t load_address;
	word_t load_instruction;
	logic retire;
	reg_addr_t retire_dest;
	word_t retire_data;

	// case file contents, flattened with per-case offsets
	word_t prog_words[$];
	int case_prog_start[$];
	int case_prog_len[$];
	reg_addr_t exp_dest[$];
	word_t exp_data[$];
	bit exp_is_time[$];
	int case_exp_start[$];
	int case_exp_len[$];

	// trace captured from the DUT
	reg_addr_t got_dest[$];
	word_t got_data[$];
	// cycles since reset release for each trace entry
	int got_cycle[$];

	int check_errors;
	int pass_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;
	bit file_ok;
	int n;

	cpu_core i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.load_write(load_write),
		.load_address(load_address),
		.load_instruction(load_instruction),
		.retire(retire),
		.retire_dest(retire_dest),
		.retire_data(retire_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// trace is registered, so it is settled by the falling edge
	always @(negedge clk) begin
		if (rst_n && retire) begin
			got_dest.push_back(retire_dest);
			got_data.push_back(retire_data);
			got_cycle.push_back(cycle_count);
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("run timed out after %0d cycles without finishing all cases",
					cycle_count);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_dest(input reg_addr_t got, input reg_addr_t expected,
		input string what);
		if (got !== expected) begin
			$display("** Error at %0t: %s wrote r%0d, expected r%0d", $time, what, got,
				expected);
			check_errors++;
		end
	endtask

	task automatic check_word(input word_t got, input word_t expected, input string what);
		if (got !== expected) begin
			$display("** Error at %0t: %s data %h, expected %h", $time, what, got, expected);
			check_errors++;
		end
	endtask

	// ordering between two timer reads
	task automatic check_word_at_least(input word_t got, input word_t floor,
		input string what);
		if ((^got === 1'bx) || (got < floor)) begin
			$display("** Error at %0t: %s time %h, expected at least %h", $time, what, got,
				floor);
			check_errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	//////////////////////////////////////////////////////////////////////
	// case file
	//////////////////////////////////////////////////////////////////////

	task automatic read_cases(output bit ok);
		int fd;
		int code;
		int c;
		int prog_base;
		int exp_base;
		logic [7:0] tag;
		word_t word;
		reg_addr_t dest;
		ok = 1'b1;
		prog_base = 0;
		exp_base = 0;
		fd = $fopen("dv/cpu_cases.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", tag);
				if (code == 1) begin
					case (tag)
						"#": begin
							c = $fgetc(fd);
							while ((c != "\n") && (c != -1)) begin
								c = $fgetc(fd);
							end
						end
						"P": begin
							code = $fscanf(fd, " %h", word);
							prog_words.push_back(word);
						end
						"E": begin
							code = $fscanf(fd, " %h %h", dest, word);
							exp_dest.push_back(dest);
							exp_data.push_back(word);
							exp_is_time.push_back(1'b0);
						end
						"T": begin
							code = $fscanf(fd, " %h", dest);
							exp_dest.push_back(dest);
							exp_data.push_back('0);
							exp_is_time.push_back(1'b1);
						end
						"X": begin
							case_prog_start.push_back(prog_base);
							case_prog_len.push_back(prog_words.size() - prog_base);
							case_exp_start.push_back(exp_base);
							case_exp_len.push_back(exp_dest.size() - exp_base);
							// budget grows with program length
							cycle_limit += (prog_words.size() - prog_base) * 8 + 50;
							prog_base = prog_words.size();
							exp_base = exp_dest.size();
						end
						default: begin
							$display("unknown tag '%c' in case file", tag);
							ok = 1'b0;
						end
					endcase
				end
			end
			$fclose(fd);
			if (prog_words.size() != prog_base) begin
				$display("last case in the case file has no end marker");
				ok = 1'b0;
			end
		end
	endtask

	task automatic run_case(input int idx);
		int pstart;
		int plen;
		int estart;
		int elen;
		int i;
		int k;
		word_t last_time;
		word_t expected_time;
		bit seen_time;
		string what;
		pstart = case_prog_start[idx];
		plen = case_prog_len[idx];
		estart = case_exp_start[idx];
		elen = case_exp_len[idx];
		check_errors = 0;
		got_dest.delete();
		got_data.delete();
		got_cycle.delete();
		// write the program, then idle load cycles
		for (i = 0; i < plen + 4; i++) begin
			load = 1'b1;
			load_write = (i < plen);
			load_address = inst_addr_t'(i);
			if (i < plen) begin
				load_instruction = prog_words[pstart + i];
			end else begin
				load_instruction = '0;
			end
			next_cycle();
		end
		load = 1'b0;
		load_write = 1'b0;
		while (got_dest.size() < elen) begin
			next_cycle();
		end
		// late or wrong-path writes land here
		repeat (10) begin
			next_cycle();
		end
		last_time = '0;
		seen_time = 1'b0;
		for (k = 0; k < elen; k++) begin
			what = $sformatf("case %0d write %0d", idx, k);
			check_dest(got_dest[k], exp_dest[estart + k], what);
			if (exp_is_time[estart + k]) begin
				// timer was read in execute, one cycle before the trace
				expected_time = word_t'((got_cycle[k] - 1) / CYCLES_PER_MS);
				check_word(got_data[k], expected_time, what);
				if (seen_time) begin
					check_word_at_least(got_data[k], last_time + word_t'(1), what);
				end
				last_time = got_data[k];
				seen_time = 1'b1;
			end else begin
				check_word(got_data[k], exp_data[estart + k], what);
			end
		end
		if (got_dest.size() > elen) begin
			$display("case %0d: %0d register writes more than expected, first extra to r%0d",
				idx, got_dest.size() - elen, got_dest[elen]);
			check_errors++;
		end
		if (check_errors == 0) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("case %0d: %0d words, %0d writes, %0d errors", idx, plen, elen,
			check_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		load = 1'b0;
		load_write = 1'b0;
		load_address = '0;
		load_instruction = '0;
		check_errors = 0;
		pass_count = 0;
		fail_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		read_cases(file_ok);
		if (!file_ok) begin
			$display("case file dv/cpu_cases.txt could not be read");
			$display("Simulation failed");
			$finish;
		end else begin
			repeat (10) begin
				@(posedge clk);
			end
			#2;
			rst_n = 1'b1;
			for (n = 0; n < case_prog_len.size(); n++) begin
				run_case(n);
			end
			$display("%0d cases passed, %0d cases failed", pass_count, fail_count);
			if ((fail_count == 0) && (pass_count > 0)) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

// ==== dv/cpu_cases.txt ====
# tags: P program word, E expected write as dest and value, all hex
# T timer read into dest, X end of case; several tags may share a line
# alu register and immediate forms, sra of a negative value
P 08400064 P 0880FFF9 P 08C00003 P 01022000
P 11423000 P 19822000 P 29C23000 P 3A043000
P 42423000 P 4A843000 P 51043000 P 214200F0
P 31828000 P 8F00FFFF
E 01 00000064 E 02 FFFFFFF9 E 03 00000003
E 04 0000005D E 05 00000061 E 06 00000060
E 07 00000067 E 08 FFFFFFFA E 09 00000320
E 0A 1FFFFFFF E 04 FFFFFFFF E 05 00000060
E 06 FFFF8064
X
# back-to-back dependent ops
P 08400005 P 00821000 P 00C41000 P 11062000
P 41484000 P 384A3000 P 08420001 P 8F00FFFF
E 01 00000005 E 02 0000000A E 03 0000000F
E 04 00000005 E 05 000000A0 E 01 000000AF
E 01 000000B0
X
# lli and lui, then use; writes to r0
P 58405678 P 60401234 P 08820000 P 60C08000
P 58C0BEEF P 29061000 P 08000005 P 01400000
P 8F00FFFF
E 02 12345678 E 04 9234FEFF E 00 00000005
E 05 00000000
X
# eight branch conditions, each after a sub
P 08400005 P 08800003 P 60C07FFF P 58C0FFFF
P 0900FFFF P 11422000 P 88000001 P 09800001
P 11422000 P 89000001 P 09800002 P 11441000
P 8A000001 P 09800003 P 11441000 P 8B000001
P 09800004 P 11421000 P 8C000001 P 09800005
P 11422000 P 8D000001 P 09800006 P 11464000
P 8E000001 P 09800007 P 11421000 P 8F000001
P 09800008 P 09800009 P 8F00FFFF
E 01 00000005 E 02 00000003 E 04 FFFFFFFF
E 05 00000002 E 05 00000002 E 06 00000002
E 05 FFFFFFFE E 06 00000003 E 05 FFFFFFFE
E 05 00000000 E 05 00000002 E 06 00000006
E 05 80000000 E 05 00000000 E 06 00000009
X
# bl into a subroutine, ret back
P 08400001 P 97000003 P 08420010 P 8F00FFFF
P 09C00055 P 08420002 P 08820004 P 98000000
P 08C00077
E 01 00000001 E 01 00000003 E 02 00000007
E 01 00000013
X
# two timer reads around a countdown loop
P E8400000 P 08800006 P 0884FFFF P 8800FFFE
P E8C00000 P 8F00FFFF
T 01
E 02 00000006 E 02 00000005 E 02 00000004
E 02 00000003 E 02 00000002 E 02 00000001
E 02 00000000
T 03
X

// ==== list.f ====
logic/cpu_pkg.sv
logic/wb_bus_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/system_timer.sv
logic/cpu_core.sv
dv/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/wb_bus_if.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/register_file.sv
  - logic/execute_stage.sv
  - logic/system_timer.sv
  - logic/cpu_core.sv
  - target: test
    files:
      - dv/cpu_tb.sv
